// File: hdl/video_pkg.sv
package video_pkg;

    // horizontal timing in pixels
    localparam int H_VISIBLE = 160;
    localparam int H_FRONT   = 8;
    localparam int H_SYNC    = 16;
    localparam int H_TOTAL   = 200;

    // vertical timing in lines
    localparam int V_VISIBLE = 120;
    localparam int V_FRONT   = 2;
    localparam int V_SYNC    = 2;
    localparam int V_TOTAL   = 130;

    localparam logic HS_ACTIVE = 1'b0;                  // hsync asserted low
    localparam logic VS_ACTIVE = 1'b0;                  // vsync asserted low

    localparam int H_CNT_W  = $clog2(H_TOTAL);          // 8 bits
    localparam int V_CNT_W  = $clog2(V_TOTAL);          // 8 bits
    localparam int PIPE_LAT = 3;                        // counters to rgb

    localparam int VRAM_AW        = 13;                 // 8k words
    localparam int PIX_PER_WORD   = 4;
    localparam int PIX_SEL_W      = $clog2(PIX_PER_WORD);
    localparam int WORDS_PER_LINE = H_VISIBLE / PIX_PER_WORD;   // 40

    localparam int COLOR_W     = 4;                     // bits per channel
    localparam int RGB_W       = 3 * COLOR_W;           // red in top bits
    localparam int PAL_ENTRIES = 16;
    localparam int PAL_IW      = $clog2(PAL_ENTRIES);
    localparam int PIX_WORD_W  = PIX_PER_WORD * PAL_IW; // 16

    typedef struct packed {
        logic [PIX_PER_WORD-1:0][PAL_IW-1:0] idx;       // idx[3] is leftmost
    } pix_bitmap_t;

    typedef struct packed {
        logic [PAL_IW-1:0]       fg;
        logic [PAL_IW-1:0]       bg;
        logic [PAL_IW-1:0]       rsvd;                  // ignored by the decoder
        logic [PIX_PER_WORD-1:0] pattern;               // msb is leftmost, 1 picks fg
    } pix_attr_t;

    // one vram word, read as bitmap or as attribute cell
    typedef union packed {
        pix_bitmap_t bm;
        pix_attr_t   at;
    } pix_word_u;

endpackage

// File: hdl/bus_pkg.sv
package bus_pkg;

    localparam logic CS_ENABLED = 1'b0;                 // chip select active low
    localparam logic RNW_READ   = 1'b1;
    localparam logic RNW_WRITE  = 1'b0;

    localparam int REG_W = 16;                          // every register is one word

    localparam logic [3:0] REG_ADDR     = 4'd0;         // vram address
    localparam logic [3:0] REG_DATA     = 4'd1;         // vram data port
    localparam logic [3:0] REG_INCR     = 4'd2;         // address step
    localparam logic [3:0] REG_MODE     = 4'd3;         // bit 0 attribute mode
    localparam logic [3:0] REG_PAL_IDX  = 4'd4;
    localparam logic [3:0] REG_PAL_DATA = 4'd5;         // 12-bit rgb
    localparam logic [3:0] REG_STATUS   = 4'd6;         // bit 0 busy

endpackage

// File: hdl/vram.sv
`timescale 1ns/1ns

module vram import video_pkg::*; (
    input  logic                  pclk,
    input  logic [VRAM_AW-1:0]    addr_i,
    input  logic                  we_i,
    input  logic [PIX_WORD_W-1:0] wdata_i,
    output logic [PIX_WORD_W-1:0] rdata_o
);

    logic [PIX_WORD_W-1:0] mem [2**VRAM_AW];        // block ram, no reset

    always_ff @(posedge pclk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];                     // one cycle read latency, old data on write
    end

endmodule

// File: hdl/bus_regs.sv
`timescale 1ns/1ns

module bus_regs import video_pkg::*, bus_pkg::*; (
    input  logic               pclk,
    input  logic               rst_i,
    input  logic               bus_cs_n_i,
    input  logic               bus_rd_nwr_i,
    input  logic               bus_bytesel_i,       // 0 upper, 1 lower
    input  logic [3:0]         bus_reg_num_i,
    input  logic [7:0]         bus_data_i,
    output logic [7:0]         bus_data_o,
    output logic               write_req_o,
    output logic               prefetch_req_o,
    output logic [VRAM_AW-1:0] vram_addr_o,
    output logic [REG_W-1:0]   wr_data_o,
    input  logic               write_done_i,
    input  logic               read_done_i,
    input  logic [REG_W-1:0]   rd_data_i,
    output logic               mode_attr_o,
    output logic               pal_we_o,
    output logic [PAL_IW-1:0]  pal_idx_o,
    output logic [RGB_W-1:0]   pal_rgb_o
);

    logic               strobe_wr, strobe_rd;
    logic               commit;                     // lower byte write ends the word
    logic               data_rd_lo;                 // lower byte read of REG_DATA
    logic [7:0]         hi_q;                       // upper byte held until commit
    logic [REG_W-1:0]   wr_word;
    logic [REG_W-1:0]   rd_word;
    logic [VRAM_AW-1:0] addr_q, incr_q;
    logic               mode_q;
    logic [PAL_IW-1:0]  pal_idx_q;
    logic [RGB_W-1:0]   pal_rgb_q;
    logic               pal_we_q;
    logic [REG_W-1:0]   wbuf_q, rbuf_q;
    logic               write_q, prefetch_q;        // level requests to the arbiter

    assign strobe_wr  = bus_cs_n_i == CS_ENABLED && bus_rd_nwr_i == RNW_WRITE;
    assign strobe_rd  = bus_cs_n_i == CS_ENABLED && bus_rd_nwr_i == RNW_READ;
    assign commit     = strobe_wr && bus_bytesel_i;
    assign data_rd_lo = strobe_rd && bus_bytesel_i && bus_reg_num_i == REG_DATA;
    assign wr_word    = {hi_q, bus_data_i};

    always_ff @(posedge pclk) begin
        if (strobe_wr && !bus_bytesel_i) begin
            hi_q <= bus_data_i;
        end
        if (commit && bus_reg_num_i == REG_DATA) begin
            wbuf_q <= wr_word;
        end
        if (commit && bus_reg_num_i == REG_PAL_DATA) begin
            pal_rgb_q <= wr_word[RGB_W-1:0];
        end
        if (read_done_i) begin
            rbuf_q <= rd_data_i;                    // prefetched word for the host
        end
    end

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            addr_q     <= '0;
            incr_q     <= '0;
            mode_q     <= 1'b0;                     // bitmap
            pal_idx_q  <= '0;
            pal_we_q   <= 1'b0;
            write_q    <= 1'b0;
            prefetch_q <= 1'b0;
        end else begin
            pal_we_q <= 1'b0;                       // single cycle pulse
            if (pal_we_q) begin
                pal_idx_q <= pal_idx_q + 1'b1;      // step after the entry is written
            end
            if (write_done_i) begin
                write_q <= 1'b0;
                addr_q  <= addr_q + incr_q;
            end
            if (read_done_i) begin
                prefetch_q <= 1'b0;
            end
            if (data_rd_lo) begin
                addr_q     <= addr_q + incr_q;      // advance, then fetch the next word
                prefetch_q <= 1'b1;
            end
            if (commit) begin
                case (bus_reg_num_i)
                    REG_ADDR: begin
                        addr_q     <= wr_word[VRAM_AW-1:0];
                        prefetch_q <= 1'b1;
                    end
                    REG_DATA:     write_q   <= 1'b1;
                    REG_INCR:     incr_q    <= wr_word[VRAM_AW-1:0];
                    REG_MODE:     mode_q    <= wr_word[0];
                    REG_PAL_IDX:  pal_idx_q <= wr_word[PAL_IW-1:0];
                    REG_PAL_DATA: pal_we_q  <= 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    always_comb begin
        case (bus_reg_num_i)
            REG_ADDR:     rd_word = REG_W'(addr_q);
            REG_DATA:     rd_word = rbuf_q;
            REG_INCR:     rd_word = REG_W'(incr_q);
            REG_MODE:     rd_word = REG_W'(mode_q);
            REG_PAL_IDX:  rd_word = REG_W'(pal_idx_q);
            REG_PAL_DATA: rd_word = REG_W'(pal_rgb_q);
            REG_STATUS:   rd_word = REG_W'(write_q | prefetch_q);   // busy
            default:      rd_word = '0;
        endcase
    end

    assign bus_data_o = !strobe_rd     ? 8'h00 :
                        bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

    assign write_req_o    = write_q;
    assign prefetch_req_o = prefetch_q;
    assign vram_addr_o    = addr_q;
    assign wr_data_o      = wbuf_q;
    assign mode_attr_o    = mode_q;
    assign pal_we_o       = pal_we_q;
    assign pal_idx_o      = pal_idx_q;
    assign pal_rgb_o      = pal_rgb_q;

endmodule

// File: hdl/vram_arbiter_fsm.sv
`timescale 1ns/1ns

module vram_arbiter_fsm import video_pkg::*, bus_pkg::*; (
    input  logic               pclk,
    input  logic               rst_i,
    input  logic               fetch_i,
    input  logic [VRAM_AW-1:0] fetch_addr_i,
    input  logic               write_req_i,
    input  logic               prefetch_req_i,
    input  logic [VRAM_AW-1:0] host_addr_i,
    input  logic [REG_W-1:0]   host_wdata_i,
    output logic [VRAM_AW-1:0] mem_addr_o,
    output logic               mem_we_o,
    output logic [REG_W-1:0]   mem_wdata_o,
    input  logic [REG_W-1:0]   mem_rdata_i,
    output logic               write_done_o,
    output logic               read_done_o,
    output logic               word_valid_o,
    output logic [REG_W-1:0]   word_o
);

    // state names the access issued in the previous cycle
    // HOST_RD is the one-cycle read return to bus_regs
    typedef enum logic [1:0] {IDLE, FETCH, HOST_WR, HOST_RD} arb_state_e;

    arb_state_e state_q, state_d;
    logic       host_free;                          // port free for a host access
    logic       do_wr, do_rd;

    // requests stay high during the done cycle, so no second issue there
    assign host_free = !fetch_i && state_q != HOST_WR && state_q != HOST_RD;
    assign do_wr     = host_free && write_req_i;
    assign do_rd     = host_free && !write_req_i && prefetch_req_i;

    always_comb begin
        if (fetch_i) begin
            state_d = FETCH;                        // display always wins
        end else if (do_wr) begin
            state_d = HOST_WR;
        end else if (do_rd) begin
            state_d = HOST_RD;
        end else begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign mem_addr_o  = fetch_i ? fetch_addr_i : host_addr_i;
    assign mem_we_o    = do_wr;
    assign mem_wdata_o = host_wdata_i;

    assign word_valid_o = state_q == FETCH;         // display word on the bus
    assign write_done_o = state_q == HOST_WR;
    assign read_done_o  = state_q == HOST_RD;       // host word on the bus
    assign word_o       = mem_rdata_i;              // vram read is already registered

endmodule

// File: hdl/video_timing.sv
`timescale 1ns/1ns

module video_timing import video_pkg::*; (
    input  logic               pclk,
    input  logic               rst_i,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,
    output logic               fetch_o,
    output logic [VRAM_AW-1:0] fetch_addr_o,
    output logic               load_o
);

    logic [H_CNT_W-1:0]  h_q;
    logic [V_CNT_W-1:0]  v_q;
    logic                hs_raw, vs_raw, de_raw;
    logic                line_end;                  // slot that fetches word 0 of next line
    logic [VRAM_AW-1:0]  row, col;
    logic [PIPE_LAT-1:0] hs_pipe, vs_pipe, de_pipe;
    logic                load_q;

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            h_q <= '0;
            v_q <= V_CNT_W'(V_TOTAL - 1);           // start in last blank line so line 0 is fetched
        end else if (h_q == H_CNT_W'(H_TOTAL - 1)) begin
            h_q <= '0;
            v_q <= (v_q == V_CNT_W'(V_TOTAL - 1)) ? '0 : v_q + 1'b1;
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    assign hs_raw = (h_q >= H_VISIBLE + H_FRONT && h_q < H_VISIBLE + H_FRONT + H_SYNC) ?
                    HS_ACTIVE : ~HS_ACTIVE;
    assign vs_raw = (v_q >= V_VISIBLE + V_FRONT && v_q < V_VISIBLE + V_FRONT + V_SYNC) ?
                    VS_ACTIVE : ~VS_ACTIVE;
    assign de_raw = h_q < H_VISIBLE && v_q < V_VISIBLE;

    assign line_end = h_q == H_CNT_W'(H_TOTAL - 2);

    always_comb begin
        if (line_end) begin
            col = '0;
            row = (v_q == V_CNT_W'(V_TOTAL - 1)) ? '0 : VRAM_AW'(v_q) + 1'b1;
        end else begin
            col = VRAM_AW'((h_q + 2'd2) / PIX_PER_WORD);    // group two pixels ahead
            row = VRAM_AW'(v_q);
        end
    end

    // one fetch per group, two cycles before its first pixel
    assign fetch_o = row < V_VISIBLE &&
                     (line_end || (h_q % PIX_PER_WORD == PIX_PER_WORD - 2 &&
                                   h_q < H_VISIBLE - 2));
    assign fetch_addr_o = row * VRAM_AW'(WORDS_PER_LINE) + col;

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            hs_pipe <= {PIPE_LAT{~HS_ACTIVE}};
            vs_pipe <= {PIPE_LAT{~VS_ACTIVE}};
            de_pipe <= '0;
            load_q  <= 1'b0;
        end else begin
            hs_pipe <= {hs_pipe[PIPE_LAT-2:0], hs_raw};
            vs_pipe <= {vs_pipe[PIPE_LAT-2:0], vs_raw};
            de_pipe <= {de_pipe[PIPE_LAT-2:0], de_raw};
            load_q  <= de_raw && h_q % PIX_PER_WORD == 0;   // shifter takes word next edge
        end
    end

    assign hsync_o = hs_pipe[PIPE_LAT-1];
    assign vsync_o = vs_pipe[PIPE_LAT-1];
    assign de_o    = de_pipe[PIPE_LAT-1];           // lines up with registered rgb
    assign load_o  = load_q;

endmodule

// File: hdl/pixel_out.sv
`timescale 1ns/1ns

module pixel_out import video_pkg::*; (
    input  logic                  pclk,
    input  logic                  rst_i,
    input  logic                  word_valid_i,
    input  logic [PIX_WORD_W-1:0] word_i,
    input  logic                  load_i,
    input  logic                  de_i,
    input  logic                  mode_attr_i,
    input  logic                  pal_we_i,
    input  logic [PAL_IW-1:0]     pal_idx_i,
    input  logic [RGB_W-1:0]      pal_rgb_i,
    output logic [COLOR_W-1:0]    red_o,
    output logic [COLOR_W-1:0]    green_o,
    output logic [COLOR_W-1:0]    blue_o
);

    pix_word_u            next_q;                   // word waiting for its group
    pix_word_u            shift_q;                  // word being displayed
    logic [PIX_SEL_W-1:0] px_q;                     // pixel within word, 0 leftmost
    logic [PIX_SEL_W-1:0] sel;
    logic [PAL_IW-1:0]    idx;
    logic [RGB_W-1:0]     pal_q [PAL_ENTRIES];
    logic [RGB_W-1:0]     rgb_q;

    always_ff @(posedge pclk) begin
        if (word_valid_i) begin
            next_q <= word_i;
        end
        if (load_i) begin
            shift_q <= next_q;
        end
    end

    assign sel = ~px_q;                             // leftmost pixel sits in the top slot

    always_comb begin
        if (mode_attr_i) begin
            idx = shift_q.at.pattern[sel] ? shift_q.at.fg : shift_q.at.bg;
        end else begin
            idx = shift_q.bm.idx[sel];
        end
    end

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                pal_q[i] <= '0;
            end
            px_q  <= '0;
            rgb_q <= '0;
        end else begin
            if (pal_we_i) begin
                pal_q[pal_idx_i] <= pal_rgb_i;
            end
            px_q  <= load_i ? '0 : px_q + 1'b1;
            rgb_q <= pal_q[idx];                    // palette lookup is the last pipe stage
        end
    end

    // blank outside the active area
    assign red_o   = de_i ? rgb_q[3*COLOR_W-1:2*COLOR_W] : '0;
    assign green_o = de_i ? rgb_q[2*COLOR_W-1:COLOR_W]   : '0;
    assign blue_o  = de_i ? rgb_q[COLOR_W-1:0]           : '0;

endmodule

// File: hdl/video_ctrl_top.sv
`timescale 1ns/1ns

module video_ctrl_top import video_pkg::*, bus_pkg::*; (
    input  logic               pclk,
    input  logic               rst_i,
    input  logic               bus_cs_n_i,
    input  logic               bus_rd_nwr_i,
    input  logic               bus_bytesel_i,
    input  logic [3:0]         bus_reg_num_i,
    input  logic [7:0]         bus_data_i,
    output logic [7:0]         bus_data_o,
    output logic [COLOR_W-1:0] red_o,
    output logic [COLOR_W-1:0] green_o,
    output logic [COLOR_W-1:0] blue_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               dv_de_o
);

    logic               write_req, prefetch_req;    // host requests to arbiter
    logic               write_done, read_done;
    logic [VRAM_AW-1:0] host_addr;
    logic [REG_W-1:0]   host_wdata;
    logic               word_valid;
    logic [REG_W-1:0]   word;                       // display or host read data
    logic               mode_attr;
    logic               pal_we;
    logic [PAL_IW-1:0]  pal_idx;
    logic [RGB_W-1:0]   pal_rgb;
    logic               fetch, load, de;
    logic [VRAM_AW-1:0] fetch_addr;
    logic [VRAM_AW-1:0] mem_addr;
    logic               mem_we;
    logic [REG_W-1:0]   mem_wdata, mem_rdata;

    bus_regs bus_regs_i (
        .pclk           (pclk),
        .rst_i          (rst_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .write_req_o    (write_req),
        .prefetch_req_o (prefetch_req),
        .vram_addr_o    (host_addr),
        .wr_data_o      (host_wdata),
        .write_done_i   (write_done),
        .read_done_i    (read_done),
        .rd_data_i      (word),
        .mode_attr_o    (mode_attr),
        .pal_we_o       (pal_we),
        .pal_idx_o      (pal_idx),
        .pal_rgb_o      (pal_rgb)
    );

    vram_arbiter_fsm vram_arbiter_fsm_i (
        .pclk           (pclk),
        .rst_i          (rst_i),
        .fetch_i        (fetch),
        .fetch_addr_i   (fetch_addr),
        .write_req_i    (write_req),
        .prefetch_req_i (prefetch_req),
        .host_addr_i    (host_addr),
        .host_wdata_i   (host_wdata),
        .mem_addr_o     (mem_addr),
        .mem_we_o       (mem_we),
        .mem_wdata_o    (mem_wdata),
        .mem_rdata_i    (mem_rdata),
        .write_done_o   (write_done),
        .read_done_o    (read_done),
        .word_valid_o   (word_valid),
        .word_o         (word)
    );

    video_timing video_timing_i (
        .pclk         (pclk),
        .rst_i        (rst_i),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .de_o         (de),
        .fetch_o      (fetch),
        .fetch_addr_o (fetch_addr),
        .load_o       (load)
    );

    vram vram_i (
        .pclk    (pclk),
        .addr_i  (mem_addr),
        .we_i    (mem_we),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    pixel_out pixel_out_i (
        .pclk         (pclk),
        .rst_i        (rst_i),
        .word_valid_i (word_valid),
        .word_i       (word),
        .load_i       (load),
        .de_i         (de),
        .mode_attr_i  (mode_attr),
        .pal_we_i     (pal_we),
        .pal_idx_i    (pal_idx),
        .pal_rgb_i    (pal_rgb),
        .red_o        (red_o),
        .green_o      (green_o),
        .blue_o       (blue_o)
    );

    assign dv_de_o = de;                            // delayed de, same stage as rgb

endmodule

// File: testbench/video_ctrl_sva.sv
`timescale 1ns/1ns

module video_ctrl_sva import video_pkg::*; (
    input logic pclk,
    input logic rst_i,
    input logic fetch_i,
    input logic mem_we_i,
    input logic req_i,                              // any pending host request
    input logic done_i,                             // write or read done
    input logic hsync_i
);

    logic hs_on;
    int   fail_count = 0;                           // failed assertion evaluations

    assign hs_on = hsync_i == HS_ACTIVE;

    // display fetch owns the vram port
    assert property (@(posedge pclk) disable iff (rst_i) fetch_i |-> !mem_we_i)
        else begin
            $error("vram write issued in a fetch cycle");
            fail_count++;
        end

    assert property (@(posedge pclk) disable iff (rst_i) $rose(req_i) |-> ##[1:3] done_i)
        else begin
            $error("host request not served within 3 cycles");
            fail_count++;
        end

    assert property (@(posedge pclk) disable iff (rst_i)
                     $rose(hs_on) |-> hs_on [*H_SYNC] ##1 !hs_on)
        else begin
            $error("hsync pulse width differs from H_SYNC");
            fail_count++;
        end

endmodule

bind vram_arbiter_fsm video_ctrl_sva arb_sva_i (
    .pclk     (pclk),
    .rst_i    (rst_i),
    .fetch_i  (fetch_i),
    .mem_we_i (mem_we_o),
    .req_i    (write_req_i | prefetch_req_i),
    .done_i   (write_done_o | read_done_o),
    .hsync_i  (1'b1)                                // idle level, no pulse here
);

bind video_timing video_ctrl_sva timing_sva_i (
    .pclk     (pclk),
    .rst_i    (rst_i),
    .fetch_i  (fetch_o),
    .mem_we_i (1'b0),
    .req_i    (1'b0),
    .done_i   (1'b0),
    .hsync_i  (hsync_o)
);

// File: testbench/tb_video_ctrl.sv
`timescale 1ns/1ns

module tb_video_ctrl import video_pkg::*, bus_pkg::*; ();

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FRAME_PIX    = H_VISIBLE * V_VISIBLE;
    localparam int FRAME_WORDS  = FRAME_PIX / PIX_PER_WORD;
    localparam int MAX_CYCLES   = 12 * FRAME_CYCLES + 20000;  // about ten frames of tests

    logic               pclk;
    logic               rst_i;
    logic               bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    logic [3:0]         bus_reg_num_i;
    logic [7:0]         bus_data_i, bus_data_o;
    logic [COLOR_W-1:0] red_o, green_o, blue_o;
    logic               hsync_o, vsync_o, dv_de_o;

    logic [31:0]        lcg_state = 32'd62;         // seed
    int                 cycle_count = 0;
    int                 pix_count = 0;              // pixels checked in current frame
    logic [15:0]        vram_model [2**VRAM_AW];
    logic [15:0]        frame_ref [FRAME_WORDS];    // vram image at frame start
    logic [11:0]        pal_model [PAL_ENTRIES];

    video_ctrl_top video_ctrl_top_i (
        .pclk          (pclk),
        .rst_i         (rst_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .red_o         (red_o),
        .green_o       (green_o),
        .blue_o        (blue_o),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .dv_de_o       (dv_de_o)
    );

    always #10 pclk = ~pclk;                        // 20 ns period

    always @(posedge pclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic int assertion_failures();
        return video_ctrl_top_i.vram_arbiter_fsm_i.arb_sva_i.fail_count +
               video_ctrl_top_i.video_timing_i.timing_sva_i.fail_count;
    endfunction

    always @(negedge pclk) begin
        if (assertion_failures() != 0) begin
            $display("a bound assertion failed by %0t ns", $time);
            $display("Result: FAILED");
            $fatal(1, "assertion");
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("error %0t ns %s got 0x%0h expected 0x%0h", $time, msg, got, exp);
            $display("Result: FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];                    // upper bits are the better ones
    endfunction

    task automatic tick();
        @(negedge pclk);                            // outputs are stable mid cycle
    endtask

    // one bus access, cs_n low across a single rising edge
    task automatic strobe_byte(input logic rnw, input logic sel, input logic [3:0] num,
                               input logic [7:0] din, output logic [7:0] dout);
        @(posedge pclk);
        #2;
        bus_cs_n_i    = CS_ENABLED;
        bus_rd_nwr_i  = rnw;
        bus_bytesel_i = sel;
        bus_reg_num_i = num;
        bus_data_i    = din;
        @(negedge pclk);
        dout = bus_data_o;                          // read data is combinational
    endtask

    task automatic release_bus();
        @(posedge pclk);
        #2;
        bus_cs_n_i = ~CS_ENABLED;
    endtask

    task automatic wait_not_busy();
        logic [7:0] st;
        st = 8'h01;
        while (st[0]) begin
            strobe_byte(RNW_READ, 1'b1, REG_STATUS, 8'h00, st);
        end
        release_bus();
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [15:0] data);
        logic [7:0] unused;
        strobe_byte(RNW_WRITE, 1'b0, num, data[15:8], unused);  // upper byte first
        strobe_byte(RNW_WRITE, 1'b1, num, data[7:0], unused);   // lower byte commits
        wait_not_busy();
    endtask

    task automatic read_reg(input logic [3:0] num, output logic [15:0] data);
        logic [7:0] hi;
        logic [7:0] lo;
        strobe_byte(RNW_READ, 1'b0, num, 8'h00, hi);
        strobe_byte(RNW_READ, 1'b1, num, 8'h00, lo);
        data = {hi, lo};
        wait_not_busy();
    endtask

    task automatic check_blank();
        check(hsync_o, !HS_ACTIVE, "hsync not idle");
        check(vsync_o, !VS_ACTIVE, "vsync not idle");
        check(dv_de_o, 1'b0, "de high");
        check({red_o, green_o, blue_o}, 0, "rgb not zero");
        check(bus_data_o, 8'h00, "bus data outside a read");
    endtask

    // palette index of pixel x in a word, leftmost pixel is slot 0
    function automatic logic [3:0] pixel_index(input logic [15:0] w, input int x,
                                               input logic attr);
        int slot;
        slot = x % PIX_PER_WORD;
        if (attr) begin
            return w[3 - slot] ? w[15:12] : w[11:8];    // pattern bit picks fg or bg
        end
        return w[15 - 4*slot -: 4];
    endfunction

    task automatic wait_vsync_fall();
        while (vsync_o !== ~VS_ACTIVE) tick();
        while (vsync_o !== VS_ACTIVE) tick();
    endtask

    task automatic measure_sync();
        int   n;
        int   lines;
        logic hs_prev, vs_prev, done;
        while (hsync_o !== ~HS_ACTIVE) tick();
        while (hsync_o !== HS_ACTIVE) tick();       // first cycle of a pulse
        n = 0;
        while (hsync_o === HS_ACTIVE) begin
            n++;
            tick();
        end
        check(n, H_SYNC, "hsync width");
        while (hsync_o === ~HS_ACTIVE) begin
            n++;
            tick();
        end
        check(n, H_TOTAL, "hsync period");
        while (dv_de_o !== 1'b1) tick();
        n = 0;
        while (dv_de_o === 1'b1) begin
            n++;
            tick();
        end
        check(n, H_VISIBLE, "de run per line");
        wait_vsync_fall();
        lines   = 0;
        hs_prev = hsync_o;
        vs_prev = vsync_o;
        done    = 1'b0;
        while (!done) begin
            tick();
            if (hs_prev === ~HS_ACTIVE && hsync_o === HS_ACTIVE) lines++;
            done    = vs_prev === ~VS_ACTIVE && vsync_o === VS_ACTIVE;
            hs_prev = hsync_o;
            vs_prev = vsync_o;
        end
        check(lines, V_TOTAL, "lines per frame");
    endtask

    task automatic write_readback();
        logic [12:0] start, incr, addr;
        logic [15:0] data, rd;
        data  = lcg_next();
        start = data[12:0];
        incr  = 13'(1 + lcg_next() % 3);
        write_reg(REG_INCR, 16'(incr));
        write_reg(REG_ADDR, 16'(start));
        addr = start;
        for (int i = 0; i < 32; i++) begin
            data = lcg_next();
            write_reg(REG_DATA, data);
            vram_model[addr] = data;
            addr = addr + incr;                     // wraps at 8k words
            read_reg(REG_ADDR, rd);
            check(rd, 16'(addr), "address after write");
        end
        write_reg(REG_ADDR, 16'(start));            // prefetches the first word
        addr = start;
        for (int i = 0; i < 32; i++) begin
            read_reg(REG_DATA, rd);
            check(rd, vram_model[addr], "readback word");
            addr = addr + incr;
            read_reg(REG_ADDR, rd);
            check(rd, 16'(addr), "address after read");
        end
    endtask

    task automatic load_palette();
        logic [15:0] c;
        write_reg(REG_PAL_IDX, 16'h0000);
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            c = lcg_next() & 16'h0fff;
            write_reg(REG_PAL_DATA, c);             // index steps by itself
            pal_model[i] = c[11:0];
        end
    endtask

    task automatic fill_vram();
        logic [15:0] d;
        write_reg(REG_INCR, 16'd1);
        write_reg(REG_ADDR, 16'd0);
        for (int a = 0; a < FRAME_WORDS; a++) begin
            d = lcg_next();
            write_reg(REG_DATA, d);
            vram_model[a] = d;
        end
    endtask

    task automatic compare_frame(input logic attr);
        int         n, x, y;
        logic [3:0] idx;
        wait_vsync_fall();
        for (int a = 0; a < FRAME_WORDS; a++) begin
            frame_ref[a] = vram_model[a];
        end
        n = 0;
        while (n < FRAME_PIX) begin
            tick();
            if (dv_de_o) begin
                x   = n % H_VISIBLE;
                y   = n / H_VISIBLE;
                idx = pixel_index(frame_ref[y*WORDS_PER_LINE + x/PIX_PER_WORD], x, attr);
                check({red_o, green_o, blue_o}, pal_model[idx],
                      $sformatf("pixel x %0d y %0d", x, y));
                n++;
                pix_count = n;
            end else begin
                check({red_o, green_o, blue_o}, 0, "rgb outside display");
            end
        end
    endtask

    // rewrites words of rows that this frame has already shown
    task automatic write_during_display();
        int          start;
        logic [15:0] d;
        while (pix_count < 60 * H_VISIBLE) tick();
        start = lcg_next() % 1900;                  // stays below row 48
        write_reg(REG_ADDR, 16'(start));
        for (int i = 0; i < 16; i++) begin
            d = lcg_next();
            write_reg(REG_DATA, d);
            vram_model[start + i] = d;
        end
    endtask

    initial begin
        logic [15:0] rd;
        pclk          = 1'b0;
        rst_i         = 1'b1;
        bus_cs_n_i    = ~CS_ENABLED;
        bus_rd_nwr_i  = RNW_READ;
        bus_bytesel_i = 1'b0;
        bus_reg_num_i = 4'd0;
        bus_data_i    = 8'h00;
        repeat (7) begin
            tick();
            check_blank();
        end
        @(posedge pclk);
        #2;
        rst_i = 1'b0;                               // 8 edges in reset
        repeat (4) begin
            tick();
            check_blank();
        end
        read_reg(REG_STATUS, rd);
        check(rd[0], 1'b0, "busy after reset");
        write_readback();
        measure_sync();
        load_palette();
        fill_vram();
        compare_frame(1'b0);                        // bitmap
        write_reg(REG_MODE, 16'd1);
        compare_frame(1'b1);                        // attribute
        write_reg(REG_INCR, 16'd1);
        pix_count = 0;
        fork
            compare_frame(1'b1);
            write_during_display();
        join
        compare_frame(1'b1);                        // new words show up here
        if (assertion_failures() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("a bound assertion failed before the end of the run");
            $display("Result: FAILED");
            $fatal(1, "assertion");
        end
    end

endmodule

// File: verilog.f
hdl/video_pkg.sv
hdl/bus_pkg.sv
hdl/vram.sv
hdl/bus_regs.sv
hdl/vram_arbiter_fsm.sv
hdl/video_timing.sv
hdl/pixel_out.sv
hdl/video_ctrl_top.sv
testbench/video_ctrl_sva.sv
testbench/tb_video_ctrl.sv

// File: Bender.yml
package:
  name: video_ctrl

sources:
  - hdl/video_pkg.sv
  - hdl/bus_pkg.sv
  - hdl/vram.sv
  - hdl/bus_regs.sv
  - hdl/vram_arbiter_fsm.sv
  - hdl/video_timing.sv
  - hdl/pixel_out.sv
  - hdl/video_ctrl_top.sv
  - target: test
    files:
      - testbench/video_ctrl_sva.sv
      - testbench/tb_video_ctrl.sv
